// ==== verilog.f ====
+incdir+src
src/fixedPointPkg.sv
src/streamPkg.sv
src/neuronNode.sv
src/stageControl.sv
src/denseLayer.sv
src/mlpNetwork.sv
bench/mlpNetworkTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module mlpNetworkTb \
	-f verilog.f \
	-Mdir obj_dir

./obj_dir/VmlpNetworkTb

// ==== bench/mlp_cases.txt ====
// per line: input activations 0 to 14, then expected outputs 0 and 1, all hex words
// 00002000 is 1.0 with 13 fraction bits
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000004C1
00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000037C 00000000
00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000005A4 00000000
00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000417
00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000029E 00000000
00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000426
00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000193
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000000CC
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 000004A8 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000205
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 0000038D
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000227
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000A21 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 000001E6
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 000001A4 00000000
00002000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000002F8 00000309
00000000 00002000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000061B 00000000
00000000 00000000 00000000 00002000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000076B
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00002000 00000000 00000000 00000ED5 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 0000055B
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000419
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00002000 00000000 00000000 00000336
00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 000004B2 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FFFFE000 00000000 00000000 00000000 000004C8
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000000CC
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 000004A8 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000205
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 0000038D
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000227
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000A21 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 000001E6
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00002000 000001A4 00000000
00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000004C1
00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000037C 00000000
00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 000005A4 00000000
00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000417
00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000029E 00000000
00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000426
00000000 00000000 00000000 00000000 00000000 00000000 00002000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000193

// ==== bench/mlpNetworkTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mlp_defines.svh"

module mlpNetworkTb
	import fixedPointPkg::*;
	import streamPkg::*;
();

	localparam int CASE_COUNT = 40;
	localparam int CASE_WORDS = `IN_COUNT + `OUT_COUNT;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int LATENCY = 2 * `LAYER_DEPTH;  // two layers back to back

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	inVecT inData;
	logic outValid;
	logic outReady;
	outVecT outData;

	logic [`WORD_WIDTH-1:0] caseMem [0:CASE_COUNT*CASE_WORDS-1];
	inVecT caseIn [CASE_COUNT];
	outVecT caseOut [CASE_COUNT];
	outVecT expectQ [$];  // results still owed by the DUT, oldest first

	int cycleCount;
	int resultCount;
	int resultCycle;
	int prevResultCycle;
	int acceptCycle;
	int sentCount;
	logic randomReady;
	logic checkGaps;
	logic haveResult;
	logic heldValid;
	outVecT heldData;

	mlpNetwork uut
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inData(inData),
		.outValid(outValid),
		.outReady(outReady),
		.outData(outData)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkOut(input string name, input outVecT got, input outVecT exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic checkCycles(input string name, input int got, input int exp);
		if (got != exp)
			abortRun($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic loadCases();
		int base;
		$readmemh("bench/mlp_cases.txt", caseMem);
		if ($isunknown(caseMem[CASE_COUNT*CASE_WORDS-1]))
			abortRun("the case file is missing or has too few words");
		for (int c = 0; c < CASE_COUNT; c++)
		begin
			base = c * CASE_WORDS;
			for (int i = 0; i < `IN_COUNT; i++)
				caseIn[c].act[i] = caseMem[base + i];
			for (int j = 0; j < `OUT_COUNT; j++)
				caseOut[c].act[j] = caseMem[base + `IN_COUNT + j];
		end
	endtask

	// presents one vector and returns on the edge that accepts it
	task automatic sendCase(input int idx);
		int waited;
		waited = 0;
		inData <= caseIn[idx];
		inValid <= 1'b1;
		@(posedge clk);
		while (!inReady)
		begin
			if (waited == TIMEOUT_CYCLES)
				abortRun("timed out waiting for inReady");
			waited++;
			@(posedge clk);
		end
		acceptCycle = cycleCount;
		expectQ.push_back(caseOut[idx]);
		sentCount++;
	endtask

	task automatic idleRandom();
		int gap;
		gap = $urandom % 3;
		repeat (gap)
		begin
			inValid <= 1'b0;
			@(posedge clk);
		end
	endtask

	task automatic waitResults(input int target);
		int waited;
		waited = 0;
		while (resultCount < target)
		begin
			if (waited == TIMEOUT_CYCLES)
				abortRun("timed out waiting for results from the DUT");
			waited++;
			@(posedge clk);
		end
	endtask

	always @(posedge clk)
	begin
		if (randomReady)
			outReady <= ($urandom % 2) == 0;
		else
			outReady <= 1'b1;
	end

	// scoreboard, sampled on the edge so values are the settled ones
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (!reset)
		begin
			if (heldValid)
			begin
				checkBit("outValid", outValid, 1'b1);
				checkOut("outData", outData, heldData);
			end
			if (!inReady)
			begin
				// input side only stalls behind a blocked output
				checkBit("outValid", outValid, 1'b1);
				checkBit("outReady", outReady, 1'b0);
			end
			if (outValid && outReady)
			begin
				if (expectQ.size() == 0)
					abortRun("a result arrived with no case outstanding");
				checkOut("outData", outData, expectQ.pop_front());
				if (checkGaps && haveResult)
					checkCycles("result spacing", cycleCount - prevResultCycle, 1);
				prevResultCycle <= cycleCount;
				resultCycle <= cycleCount;
				haveResult <= 1'b1;
				resultCount <= resultCount + 1;
			end
			heldValid <= outValid && !outReady;
			heldData <= outData;
		end
	end

	initial
	begin
		void'($urandom(32'h98c7));
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		outReady = 1'b1;
		randomReady = 1'b0;
		checkGaps = 1'b0;
		haveResult = 1'b0;
		heldValid = 1'b0;
		heldData = '0;
		cycleCount = 0;
		resultCount = 0;
		resultCycle = 0;
		prevResultCycle = 0;
		acceptCycle = 0;
		sentCount = 0;
		loadCases();

		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		checkBit("outValid", outValid, 1'b0);
		checkBit("inReady", inReady, 1'b1);

		// lone vectors, case 0 is all zero so only the biases act
		for (int c = 0; c < 2; c++)
		begin
			sendCase(c);
			inValid <= 1'b0;
			waitResults(sentCount);
			checkCycles("latency", resultCycle - acceptCycle, LATENCY);
		end

		checkGaps <= 1'b1;
		haveResult <= 1'b0;
		for (int c = 0; c < CASE_COUNT; c++)
			sendCase(c);
		inValid <= 1'b0;
		waitResults(sentCount);
		checkGaps <= 1'b0;

		randomReady <= 1'b1;
		for (int c = 0; c < CASE_COUNT; c++)
			sendCase(c);
		inValid <= 1'b0;
		waitResults(sentCount);

		for (int c = 0; c < CASE_COUNT; c++)
		begin
			idleRandom();
			sendCase(c);
		end
		inValid <= 1'b0;
		waitResults(sentCount);
		randomReady <= 1'b0;
		@(posedge clk);

		// every case is answered, so nothing may be left in the output stage
		if (outValid !== 1'b0)
			abortRun("outValid is still high after every case was answered");
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== src/mlpNetwork.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mlp_defines.svh"

module mlpNetwork
	import fixedPointPkg::*;
	import streamPkg::*;
(
	input wire logic clk,
	input wire logic reset,

	input wire logic inValid,
	output logic inReady,
	input wire inVecT inData,

	output logic outValid,
	input wire logic outReady,
	output outVecT outData
);

	// rows are written bias first, then the highest weight down to weight 0
	localparam weightRowT HIDDEN_ROW0 = {
		-32'sd413,
		-32'sd915, -32'sd490, 32'sd6339, -32'sd331,
		-32'sd121, -32'sd2816, 32'sd946, 32'sd402,
		-32'sd3707, -32'sd1245, -32'sd1781, -32'sd2134,
		32'sd4781, -32'sd3534, 32'sd1200
	};

	localparam weightRowT HIDDEN_ROW1 = {
		32'sd250,
		-32'sd1502, 32'sd671, -32'sd2304, 32'sd1745,
		-32'sd388, 32'sd2561, -32'sd1120, 32'sd833,
		-32'sd2977, 32'sd1408, -32'sd642, 32'sd3075,
		32'sd512, -32'sd1893, 32'sd2210
	};

	localparam weightRowT HIDDEN_ROW2 = {
		-32'sd1180,
		32'sd2043, -32'sd3316, 32'sd784, 32'sd159,
		-32'sd4420, 32'sd1297, 32'sd3688, -32'sd905,
		32'sd217, -32'sd1564, 32'sd2931, -32'sd46,
		-32'sd2675, 32'sd3902, -32'sd731
	};

	localparam weightRowT HIDDEN_ROW3 = {
		32'sd637,
		32'sd388, 32'sd1476, -32'sd2519, -32'sd3071,
		32'sd5210, -32'sd812, 32'sd95, -32'sd1933,
		32'sd2648, 32'sd3340, -32'sd477, -32'sd1205,
		32'sd1862, -32'sd2788, 32'sd4013
	};

	// output rows only use four weights, the rest is padding
	localparam weightRowT OUT_ROW0 = {
		{(ROW_WORDS - `HIDDEN_COUNT - 1){32'sd0}},
		-32'sd120,
		-32'sd980, 32'sd1875, -32'sd2450, 32'sd3120
	};

	localparam weightRowT OUT_ROW1 = {
		{(ROW_WORDS - `HIDDEN_COUNT - 1){32'sd0}},
		32'sd300,
		32'sd1430, -32'sd2240, 32'sd2790, -32'sd1610
	};

	localparam weightRowT [`HIDDEN_COUNT-1:0] HIDDEN_WEIGHTS = {
		HIDDEN_ROW3, HIDDEN_ROW2, HIDDEN_ROW1, HIDDEN_ROW0
	};

	localparam weightRowT [`OUT_COUNT-1:0] OUT_WEIGHTS = {OUT_ROW1, OUT_ROW0};

	// stream between the two layers
	hiddenVecT hiddenData;
	logic hiddenValid;
	logic hiddenReady;

	denseLayer #(
		.INPUTS(`IN_COUNT),
		.NEURONS(`HIDDEN_COUNT),
		.WEIGHT_TABLE(HIDDEN_WEIGHTS)
	) hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inAct(inData.act),
		.outValid(hiddenValid),
		.outReady(hiddenReady),
		.outAct(hiddenData.act)
	);

	denseLayer #(
		.INPUTS(`HIDDEN_COUNT),
		.NEURONS(`OUT_COUNT),
		.WEIGHT_TABLE(OUT_WEIGHTS)
	) outputLayer
	(
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inReady(hiddenReady),
		.inAct(hiddenData.act),
		.outValid(outValid),
		.outReady(outReady),
		.outAct(outData.act)
	);

endmodule

`default_nettype wire

// ==== src/denseLayer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mlp_defines.svh"

module denseLayer
	import fixedPointPkg::*;
#(
	parameter int INPUTS = `IN_COUNT,
	parameter int NEURONS = `HIDDEN_COUNT,
	parameter weightRowT [NEURONS-1:0] WEIGHT_TABLE = '0
)
(
	input wire logic clk,
	input wire logic reset,

	// upstream handshake
	input wire logic inValid,
	output logic inReady,
	input wire activationT [INPUTS-1:0] inAct,

	// downstream handshake
	output logic outValid,
	input wire logic outReady,
	output activationT [NEURONS-1:0] outAct
);

	logic advance;  // shared by every neuron

	stageControl control
	(
		.clk(clk),
		.reset(reset),
		.upValid(inValid),
		.upReady(inReady),
		.downValid(outValid),
		.downReady(outReady),
		.advance(advance)
	);

	// all neurons see the same input vector, each with its own row
	for (genvar n = 0; n < NEURONS; n++)
	begin : gNeuron
		neuronNode #(
			.INPUTS(INPUTS),
			.WEIGHTS(WEIGHT_TABLE[n])
		) node
		(
			.clk(clk),
			.reset(reset),
			.advance(advance),
			.inAct(inAct),
			.result(outAct[n])
		);
	end

	// data on a blocked output must not change under the consumer
	property pDataHold;
		@(posedge clk) disable iff (reset)
		outValid && !outReady |=> $stable(outAct);
	endproperty

	assert property (pDataHold)
	else $error("denseLayer: outAct changed while the output was stalled");

endmodule

`default_nettype wire

// ==== src/stageControl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mlp_defines.svh"

module stageControl
(
	input wire logic clk,
	input wire logic reset,
	input wire logic upValid,
	output logic upReady,
	output logic downValid,
	input wire logic downReady,
	output logic advance
);

	localparam int LAST = `LAYER_DEPTH - 1;

	// one valid bit per pipeline stage, bit 0 is the capture stage
	logic [`LAYER_DEPTH-1:0] stageValid;

	// whole pipe moves together, bubbles are kept
	assign advance = !stageValid[LAST] || downReady;
	assign upReady = advance;
	assign downValid = stageValid[LAST];

	always_ff @(posedge clk)
	begin
		if (reset)
			stageValid <= '0;
		else if (advance)
			stageValid <= {stageValid[LAST-1:0], upValid};
	end

	// a result offered downstream must wait there until taken
	property pValidHold;
		@(posedge clk) disable iff (reset)
		downValid && !downReady |=> downValid;
	endproperty

	assert property (pValidHold)
	else $error("stageControl: downValid dropped before it was accepted");

endmodule

`default_nettype wire

// ==== src/neuronNode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mlp_defines.svh"

module neuronNode
	import fixedPointPkg::*;
#(
	parameter int INPUTS = `IN_COUNT,
	parameter weightRowT WEIGHTS = '0
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic advance,
	input wire activationT [INPUTS-1:0] inAct,
	output activationT result
);

	localparam int RESCALE_WIDTH = `RESCALE_MSB - `FRAC_BITS + 1;

	activationT [INPUTS-1:0] actReg;  // stage 1
	accumT sumReg;                    // stage 2
	accumT weightedSum;
	activationT rescaled;

	// multiply-accumulate, low word of every product is kept
	always_comb
	begin
		weightedSum = accumT'(WEIGHTS[INPUTS]);  // start from bias
		for (int i = 0; i < INPUTS; i++)
		begin
			weightedSum = weightedSum + actReg[i] * accumT'(WEIGHTS[i]);
		end
	end

	assign rescaled = {{(`WORD_WIDTH - RESCALE_WIDTH){1'b0}},
		sumReg[`RESCALE_MSB:`FRAC_BITS]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else if (advance)
		begin
			actReg <= inAct;
			sumReg <= weightedSum;

			// relu, negative sums clamp to zero
			if (sumReg[`WORD_WIDTH-1])
				result <= '0;
			else
				result <= rescaled;
		end
	end

endmodule

`default_nettype wire

// ==== src/streamPkg.sv ====
`default_nettype none

`include "mlp_defines.svh"

package streamPkg;

	import fixedPointPkg::*;

	// network input vector
	typedef struct packed {
		activationT [`IN_COUNT-1:0] act;
	} inVecT;

	// hidden layer -> output layer
	typedef struct packed {
		activationT [`HIDDEN_COUNT-1:0] act;
	} hiddenVecT;

	// network result
	typedef struct packed {
		activationT [`OUT_COUNT-1:0] act;
	} outVecT;

endpackage

`default_nettype wire

// ==== src/fixedPointPkg.sv ====
`default_nettype none

`include "mlp_defines.svh"

package fixedPointPkg;

	// widest row holds IN_COUNT weights plus the bias
	localparam int ROW_WORDS = `IN_COUNT + 1;

	// activations are treated as raw fixed-point words
	typedef logic [`WORD_WIDTH-1:0] activationT;

	typedef logic signed [`WORD_WIDTH-1:0] weightT;

	// sums wrap at the word width
	typedef logic [`WORD_WIDTH-1:0] accumT;

	// entry i is weight i for i < INPUTS, entry INPUTS is the bias
	// entries above the bias are padding and stay zero
	typedef weightT [ROW_WORDS-1:0] weightRowT;

endpackage

`default_nettype wire

// ==== src/mlp_defines.svh ====
`ifndef MLP_DEFINES_SVH
`define MLP_DEFINES_SVH

// data path width
`define WORD_WIDTH 32

// network shape
`define IN_COUNT 15
`define HIDDEN_COUNT 4
`define OUT_COUNT 2

// ReLU rescale window, sum bits RESCALE_MSB down to FRAC_BITS
`define FRAC_BITS 13
`define RESCALE_MSB 28

// register stages per dense layer
`define LAYER_DEPTH 3

`endif
